// ==== tb.f ====
+incdir+common
common/raster_pkg.sv
design/stream_fifo.sv
design/triangle_assembler.sv
design/viewport_transform.sv
design/triangle_frustum_culler.sv
design/cull_counter.sv
design/geometry_frontend.sv
bench/frontend_checker.sv
bench/tb_geometry_frontend.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_geometry_frontend -o sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST FAILED ***" sim.log; then
    exit 1
fi
if ! grep -qF "*** TEST PASSED ***" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

// ==== bench/tb_geometry_frontend.sv ====
`timescale 1ns/1ps

module tb_geometry_frontend import raster_pkg::*;;

    localparam int TOTAL_VERTICES = 3 * (30 + 60 + 30 + 60 + 10);
    localparam int CYCLE_LIMIT    = 8 * TOTAL_VERTICES + 200;

    logic            clk;
    logic            rst;
    vertex_t         vertex_in;
    logic            vertex_valid;
    logic            vertex_ready;
    triangle_t       tri_out;
    logic            tri_valid;
    logic            tri_ready;
    logic            stats_clear;
    frontend_stats_t stats;
    logic            check_idle;
    logic            drained;
    logic            backpressure;
    int              errors;
    int              base;
    int              cycles = 0;
    int              tests_passed = 0;
    int              tests_failed = 0;

    geometry_frontend dut (.*);

    frontend_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    always @(negedge clk) begin
        tri_ready = backpressure ? (($urandom % 10) < 3) : 1'b1; // 30 percent when throttled.
    end

    function automatic fixed_t rand_range(input int lo, input int span);
        return fixed_t'(lo + int'($urandom % span));
    endfunction

    // kind 0 is inside, 1 to 5 miss near, far, right, left, top or bottom.
    function automatic vertex_t rand_vertex(input int kind);
        vertex_t v;
        v.pos.x = rand_range(-65536, 131073);
        v.pos.y = rand_range(-65536, 131073);
        v.pos.z = rand_range(-1000 * 65536, 999 * 65536 + 1);
        case (kind)
            1: v.pos.z = rand_range(-64880, 196000);
            2: v.pos.z = rand_range(-1100 * 65536, 100 * 65536);
            3: v.pos.x = rand_range(65537, 131072);
            4: v.pos.x = rand_range(-196608, 131072);
            5: v.pos.y = ($urandom % 2) ? rand_range(65537, 131072) : rand_range(-196608, 131072);
            default: ;
        endcase
        return v;
    endfunction

    task automatic send_triangles(input int count, input bit mixed, input bit gaps);
        int mode;
        int kind;
        for (int t = 0; t < count; t++) begin
            mode = mixed ? int'($urandom % 7) : 0;
            for (int i = 0; i < 3; i++) begin
                kind = mode;
                if (mode == 6) kind = (i == 0) ? 0 : 1 + int'($urandom % 5); // partly inside.
                if (gaps) repeat ($urandom % 3) @(negedge clk);
                vertex_in    = rand_vertex(kind);
                vertex_valid = 1'b1;
                while (!vertex_ready) @(negedge clk);
                @(negedge clk);
                vertex_valid = 1'b0;
            end
        end
    endtask

    task automatic idle_check();
        check_idle = 1'b1;
        @(negedge clk);
        check_idle = 1'b0;
    endtask

    task automatic finish_test(input int num, input string name);
        while (!drained) @(negedge clk);
        idle_check();
        if (errors == base) begin
            tests_passed++;
            $display("test %0d %s: passed", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", num, name, errors - base);
        end
        base = errors;
    endtask

    initial begin
        void'($urandom(32'habba));
        rst          = 1'b1;
        vertex_in    = '0;
        vertex_valid = 1'b0;
        tri_ready    = 1'b1;
        stats_clear  = 1'b0;
        check_idle   = 1'b0;
        backpressure = 1'b0;
        base         = 0;
        repeat (8) @(negedge clk);
        idle_check(); // still in reset.
        repeat (7) @(negedge clk);
        rst = 1'b0;
        finish_test(1, "reset state");
        send_triangles(30, 1'b0, 1'b0);
        finish_test(2, "visible triangles");
        send_triangles(60, 1'b1, 1'b0);
        finish_test(3, "mixed culling");
        backpressure = 1'b1;
        send_triangles(30, 1'b0, 1'b1);
        send_triangles(60, 1'b1, 1'b1);
        backpressure = 1'b0;
        finish_test(4, "back-pressure");
        stats_clear = 1'b1;
        @(negedge clk);
        stats_clear = 1'b0;
        idle_check();
        send_triangles(10, 1'b1, 1'b0);
        finish_test(5, "statistics clear");
        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== bench/frontend_checker.sv ====
`timescale 1ns/1ps

`include "raster_defs.svh"

module frontend_checker import raster_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  vertex_t         vertex_in,
    input  logic            vertex_valid,
    input  logic            vertex_ready,
    input  triangle_t       tri_out,
    input  logic            tri_valid,
    input  logic            tri_ready,
    input  logic            stats_clear,
    input  frontend_stats_t stats,
    input  logic            check_idle,
    output logic            drained,
    output int              errors
);

    localparam int STAT_MAX = (1 << `STAT_WIDTH) - 1;

    vertex_t   pending[$]; // vertices of the triangle being gathered.
    triangle_t expected[$];
    int        exp_kept = 0;
    int        exp_culled = 0;
    int        tri_seen = 0;

    initial begin
        errors  = 0;
        drained = 1'b0;
    end

    // screen mapping done in 64 bits, then cut back to Q16.16.
    function automatic vertex_t map_vertex(input vertex_t v);
        vertex_t r;
        longint  sx;
        longint  sy;
        sx = ((longint'(v.pos.x) + 65536) * `SCREEN_WIDTH) / 2;
        sy = ((65536 - longint'(v.pos.y)) * `SCREEN_HEIGHT) / 2;
        r.pos.x = sx[31:0];
        r.pos.y = sy[31:0];
        r.pos.z = v.pos.z;
        return r;
    endfunction

    function automatic bit visible(input vertex_t s);
        longint depth;
        depth = -longint'(s.pos.z);
        return depth >= longint'(`NEAR_PLANE) * 65536 && depth <= longint'(`FAR_PLANE) * 65536
            && s.pos.x >= 0 && longint'(s.pos.x) <= longint'(`SCREEN_WIDTH) * 65536
            && s.pos.y >= 0 && longint'(s.pos.y) <= longint'(`SCREEN_HEIGHT) * 65536;
    endfunction

    always @(posedge clk) begin
        triangle_t t;
        if (check_idle) begin
            if (tri_valid || !vertex_ready) begin
                $display("FAILED at %0t: idle flags tri_valid=%0b vertex_ready=%0b",
                         $time, tri_valid, vertex_ready);
                errors++;
            end
            if (int'(stats.kept_count) != exp_kept || int'(stats.culled_count) != exp_culled) begin
                $display("FAILED at %0t: counts kept %0d culled %0d, expected %0d and %0d",
                         $time, stats.kept_count, stats.culled_count, exp_kept, exp_culled);
                errors++;
            end
        end
        if (rst) begin
            pending.delete();
            expected.delete();
        end else begin
            if (stats_clear) begin
                exp_kept   = 0;
                exp_culled = 0;
            end
            if (vertex_valid && vertex_ready) begin
                pending.push_back(map_vertex(vertex_in));
                if (pending.size() == 3) begin
                    t = {pending[0], pending[1], pending[2]};
                    pending.delete();
                    if (visible(t.v0) || visible(t.v1) || visible(t.v2)) begin
                        expected.push_back(t);
                        if (exp_kept < STAT_MAX) exp_kept++;
                    end else if (exp_culled < STAT_MAX) begin
                        exp_culled++;
                    end
                end
            end
            if (tri_valid && tri_ready) begin
                if (expected.size() == 0) begin
                    $display("ERROR at %0t: a triangle came out when none was expected", $time);
                    errors++;
                end else begin
                    t = expected.pop_front();
                    if (tri_out !== t) begin
                        $display("FAILED at %0t: triangle %0d is %h, expected %h",
                                 $time, tri_seen, tri_out, t);
                        errors++;
                    end
                    tri_seen++;
                end
            end
            drained = expected.size() == 0 && pending.size() == 0 && !tri_valid &&
                int'(stats.kept_count) + int'(stats.culled_count) == exp_kept + exp_culled;
        end
    end

endmodule

// ==== design/geometry_frontend.sv ====
`timescale 1ns/1ps

`include "raster_defs.svh"

module geometry_frontend import raster_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  vertex_t         vertex_in,
    input  logic            vertex_valid,
    output logic            vertex_ready,
    output triangle_t       tri_out,
    output logic            tri_valid,
    input  logic            tri_ready,
    input  logic            stats_clear,
    output frontend_stats_t stats
);

    vertex_t     fifo_vertex;
    logic        fifo_vertex_valid;
    logic        asm_ready;

    triangle_t   asm_tri;
    logic        asm_valid;
    logic        xform_ready;

    triangle_t   xform_tri;
    logic        xform_valid;
    logic        cull_ready;

    triangle_t   cull_tri;
    logic        cull_valid;
    logic        tri_fifo_ready;

    cull_event_t cull_event;

    stream_fifo #(
        .T     (vertex_t),
        .DEPTH (`VERTEX_FIFO_DEPTH)
    ) u_vertex_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (vertex_in),
        .in_valid  (vertex_valid),
        .in_ready  (vertex_ready),
        .out_data  (fifo_vertex),
        .out_valid (fifo_vertex_valid),
        .out_ready (asm_ready)
    );

    triangle_assembler u_assembler (
        .clk       (clk),
        .rst       (rst),
        .vertex    (fifo_vertex),
        .in_valid  (fifo_vertex_valid),
        .in_ready  (asm_ready),
        .tri_out   (asm_tri),
        .out_valid (asm_valid),
        .out_ready (xform_ready)
    );

    viewport_transform u_transform (
        .clk       (clk),
        .rst       (rst),
        .tri_in    (asm_tri),
        .in_valid  (asm_valid),
        .in_ready  (xform_ready),
        .tri_out   (xform_tri),
        .out_valid (xform_valid),
        .out_ready (cull_ready)
    );

    triangle_frustum_culler u_culler (
        .clk       (clk),
        .rst       (rst),
        .tri_in    (xform_tri),
        .in_valid  (xform_valid),
        .in_ready  (cull_ready),
        .tri_out   (cull_tri),
        .out_valid (cull_valid),
        .out_ready (tri_fifo_ready),
        .event_out (cull_event)
    );

    stream_fifo #(
        .T     (triangle_t),
        .DEPTH (`TRIANGLE_FIFO_DEPTH)
    ) u_triangle_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (cull_tri),
        .in_valid  (cull_valid),
        .in_ready  (tri_fifo_ready),
        .out_data  (tri_out),
        .out_valid (tri_valid),
        .out_ready (tri_ready)
    );

    cull_counter u_counter (
        .clk         (clk),
        .rst         (rst),
        .event_in    (cull_event),
        .stats_clear (stats_clear),
        .stats       (stats)
    );

endmodule

// ==== design/cull_counter.sv ====
`timescale 1ns/1ps

module cull_counter import raster_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  cull_event_t     event_in,
    input  logic            stats_clear,
    output frontend_stats_t stats
);

    frontend_stats_t stats_reg;

    // holds at all ones.
    function automatic logic [$bits(stats_reg.kept_count)-1:0] sat_inc(
        input logic [$bits(stats_reg.kept_count)-1:0] c
    );
        return (&c) ? c : c + 1'b1;
    endfunction

    assign stats = stats_reg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stats_reg <= '0;
        end else if (stats_clear) begin
            stats_reg <= '0; // clear wins over a same-cycle pulse.
        end else begin
            if (event_in.kept) stats_reg.kept_count <= sat_inc(stats_reg.kept_count);
            if (event_in.culled) stats_reg.culled_count <= sat_inc(stats_reg.culled_count);
        end
    end

endmodule

// ==== design/triangle_frustum_culler.sv ====
`timescale 1ns/1ps

`include "raster_defs.svh"

module triangle_frustum_culler import raster_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  triangle_t   tri_in,
    input  logic        in_valid,
    output logic        in_ready,
    output triangle_t   tri_out,
    output logic        out_valid,
    input  logic        out_ready,
    output cull_event_t event_out
);

    localparam fixed_t NEAR_Q   = `NEAR_PLANE * 65536;
    localparam fixed_t FAR_Q    = `FAR_PLANE * 65536;
    localparam fixed_t WIDTH_Q  = `SCREEN_WIDTH * 65536;
    localparam fixed_t HEIGHT_Q = `SCREEN_HEIGHT * 65536;

    triangle_t tri_reg;
    logic      valid_reg;
    logic      keep;

    function automatic logic vertex_inside(input vertex_t v);
        fixed_t depth;
        depth = -v.pos.z; // camera looks down minus z.
        return (depth >= NEAR_Q) && (depth <= FAR_Q) &&
               (v.pos.x >= 0) && (v.pos.x <= WIDTH_Q) &&
               (v.pos.y >= 0) && (v.pos.y <= HEIGHT_Q);
    endfunction

    // partly visible triangles go through whole.
    assign keep = vertex_inside(tri_reg.v0) ||
                  vertex_inside(tri_reg.v1) ||
                  vertex_inside(tri_reg.v2);

    // a culled entry always drains in one cycle.
    assign in_ready  = !valid_reg || !keep || out_ready;
    assign out_valid = valid_reg && keep;
    assign tri_out   = tri_reg;

    assign event_out.kept   = valid_reg && keep && out_ready;
    assign event_out.culled = valid_reg && !keep;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_reg <= 1'b0;
        end else if (in_ready) begin
            valid_reg <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready && in_valid) begin
            tri_reg <= tri_in;
        end
    end

endmodule

// ==== design/viewport_transform.sv ====
`timescale 1ns/1ps

`include "raster_defs.svh"

module viewport_transform import raster_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  triangle_t tri_in,
    input  logic      in_valid,
    output logic      in_ready,
    output triangle_t tri_out,
    output logic      out_valid,
    input  logic      out_ready
);

    localparam fixed_t ONE    = 32'sh0001_0000; // 1.0 in Q16.16.
    localparam int     HALF_W = `SCREEN_WIDTH / 2;
    localparam int     HALF_H = `SCREEN_HEIGHT / 2;

    triangle_t tri_reg;
    logic      valid_reg;

    // integer scale, so the product stays exact in Q16.16.
    function automatic vertex_t to_screen(input vertex_t v);
        vertex_t r;
        r.pos.x = fixed_t'((v.pos.x + ONE) * HALF_W);
        r.pos.y = fixed_t'((ONE - v.pos.y) * HALF_H); // y grows downward on screen.
        r.pos.z = v.pos.z;
        return r;
    endfunction

    assign in_ready  = !valid_reg || out_ready;
    assign out_valid = valid_reg;
    assign tri_out   = tri_reg;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_reg <= 1'b0;
        end else if (in_ready) begin
            valid_reg <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready && in_valid) begin
            tri_reg.v0 <= to_screen(tri_in.v0);
            tri_reg.v1 <= to_screen(tri_in.v1);
            tri_reg.v2 <= to_screen(tri_in.v2);
        end
    end

endmodule

// ==== design/triangle_assembler.sv ====
`timescale 1ns/1ps

module triangle_assembler import raster_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  vertex_t   vertex,
    input  logic      in_valid,
    output logic      in_ready,
    output triangle_t tri_out,
    output logic      out_valid,
    input  logic      out_ready
);

    typedef enum logic [1:0] {
        WAIT_V0,
        WAIT_V1,
        WAIT_V2,
        HOLD
    } asm_state_t;

    asm_state_t state;
    triangle_t  tri_reg;
    logic       accept;

    assign in_ready  = (state != HOLD); // stalled while a triangle waits.
    assign out_valid = (state == HOLD);
    assign tri_out   = tri_reg;
    assign accept    = in_valid && in_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= WAIT_V0;
        end else begin
            case (state)
                WAIT_V0: if (accept) state <= WAIT_V1;
                WAIT_V1: if (accept) state <= WAIT_V2;
                WAIT_V2: if (accept) state <= HOLD;
                HOLD:    if (out_ready) state <= WAIT_V0;
                default: state <= WAIT_V0;
            endcase
        end
    end

    // slots filled in arrival order.
    always_ff @(posedge clk) begin
        if (accept) begin
            case (state)
                WAIT_V0: tri_reg.v0 <= vertex;
                WAIT_V1: tri_reg.v1 <= vertex;
                WAIT_V2: tri_reg.v2 <= vertex;
                default: tri_reg <= tri_reg;
            endcase
        end
    end

endmodule

// ==== design/stream_fifo.sv ====
`timescale 1ns/1ps

module stream_fifo #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  T     in_data,
    input  logic in_valid,
    output logic in_ready,
    output T     out_data,
    output logic out_valid,
    input  logic out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // pointers wrap at DEPTH, not at a power of two.
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr]; // head entry.
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== common/raster_pkg.sv ====
`include "raster_defs.svh"

package raster_pkg;

    // Q16.16, signed.
    typedef logic signed [31:0] fixed_t;

    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } vec3_t;

    typedef struct packed {
        vec3_t pos;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    // one-cycle pulses from the culler.
    typedef struct packed {
        logic kept;
        logic culled;
    } cull_event_t;

    typedef struct packed {
        logic [`STAT_WIDTH-1:0] kept_count;
        logic [`STAT_WIDTH-1:0] culled_count;
    } frontend_stats_t;

endpackage

// ==== common/raster_defs.svh ====
`ifndef RASTER_DEFS_SVH
`define RASTER_DEFS_SVH

// screen size in pixels.
`define SCREEN_WIDTH  320
`define SCREEN_HEIGHT 240

// view depth along minus z.
`define NEAR_PLANE 1
`define FAR_PLANE  1000

`define VERTEX_FIFO_DEPTH   4
`define TRIANGLE_FIFO_DEPTH 4

`define STAT_WIDTH 16

`endif
